// File: design/ex_pkg.sv
package ex_pkg;

  // Data word, register address and operator widths
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [4:0]  op_code_t;

  ////////////////////////////////////////
  // Operator codes
  ////////////////////////////////////////

  // ALU data operators
  localparam op_code_t OP_ADD   = 5'd0;
  localparam op_code_t OP_SUB   = 5'd1;
  localparam op_code_t OP_AND   = 5'd2;
  localparam op_code_t OP_OR    = 5'd3;
  localparam op_code_t OP_XOR   = 5'd4;
  localparam op_code_t OP_SLL   = 5'd5;
  localparam op_code_t OP_SRL   = 5'd6;
  localparam op_code_t OP_SRA   = 5'd7;
  localparam op_code_t OP_SLT   = 5'd8;
  localparam op_code_t OP_SLTU  = 5'd9;

  // Branch compares, result is the outcome as 0 or 1
  localparam op_code_t OP_BEQ   = 5'd10;
  localparam op_code_t OP_BNE   = 5'd11;
  localparam op_code_t OP_BLT   = 5'd12;
  localparam op_code_t OP_BGE   = 5'd13;
  localparam op_code_t OP_BLTU  = 5'd14;
  localparam op_code_t OP_BGEU  = 5'd15;

  // Multiplier operators
  localparam op_code_t OP_MUL   = 5'd16;
  localparam op_code_t OP_MULHU = 5'd17;

  ////////////////////////////////////////
  // Multiplier
  ////////////////////////////////////////

  // One shift-add step per operand bit
  localparam int MULT_CYCLES = 32;

  typedef logic [$clog2(MULT_CYCLES)-1:0] mult_cnt_t;
  localparam mult_cnt_t MULT_LAST = mult_cnt_t'(MULT_CYCLES - 1);

  typedef enum logic [1:0] {
    MULT_IDLE,
    MULT_BUSY,
    MULT_DONE
  } mult_state_e;

endpackage

// File: design/ex_op_if.sv
`timescale 1ns/1ns

// Gated, decoded instruction from decode to the units and result register
interface ex_op_if;

  logic              valid;
  logic              alu_en;
  logic              mul_en;
  ex_pkg::op_code_t  operator;
  ex_pkg::word_t     operand_a;
  ex_pkg::word_t     operand_b;
  logic              rf_we;
  ex_pkg::reg_addr_t rf_waddr;
  logic              branch;
  logic              illegal;
  logic              kill;
  logic              halt;

  modport decode (output valid, alu_en, mul_en, operator, operand_a, operand_b,
                         rf_we, rf_waddr, branch, illegal, kill, halt);

  modport unit   (input  valid, alu_en, mul_en, operator, operand_a, operand_b,
                         branch, kill);

  modport result (input  valid, alu_en, mul_en, rf_we, rf_waddr, branch, illegal,
                         kill, halt);

endinterface

// File: design/fu_result_if.sv
`timescale 1ns/1ns

// Functional unit results towards the EX/WB register
interface fu_result_if;

  ex_pkg::word_t alu_result;
  logic          cmp_result;
  ex_pkg::word_t mul_result;
  logic          mul_valid;
  logic          mul_ready;
  // Downstream ready, fed back to the multiplier
  logic          wb_ready;

  modport alu    (output alu_result, cmp_result);

  modport mult   (output mul_result, mul_valid, mul_ready, input wb_ready);

  modport result (input  alu_result, cmp_result, mul_result, mul_valid, mul_ready,
                  output wb_ready);

endinterface

// File: design/ex_issue_decode.sv
`timescale 1ns/1ns

module ex_issue_decode (
  input  logic              instr_valid_i,
  input  logic              kill_i,
  input  logic              halt_i,
  input  logic              alu_en_i,
  input  logic              mul_en_i,
  input  logic              branch_i,
  input  logic              rf_we_i,
  input  ex_pkg::op_code_t  operator_i,
  input  ex_pkg::word_t     operand_a_i,
  input  ex_pkg::word_t     operand_b_i,
  input  ex_pkg::reg_addr_t rf_waddr_i,
  ex_op_if.decode           op
);

  import ex_pkg::*;

  // Operator class of the issued code
  logic is_alu_op;
  logic is_cmp_op;
  logic is_mul_op;
  logic illegal;

  assign is_cmp_op = operator_i inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
  assign is_alu_op = is_cmp_op ||
                     (operator_i inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                         OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU});
  assign is_mul_op = operator_i inside {OP_MUL, OP_MULHU};

  // Exactly one unit, operator owned by that unit, branches only on compares
  assign illegal = (alu_en_i == mul_en_i)     ||
                   (alu_en_i && !is_alu_op)   ||
                   (mul_en_i && !is_mul_op)   ||
                   (branch_i && !is_cmp_op);

  // Kill and halt both turn the slot into a bubble
  assign op.valid     = instr_valid_i && !kill_i && !halt_i;
  assign op.kill      = kill_i;
  assign op.halt      = halt_i;

  // No unit starts and no register write for an illegal instruction
  assign op.alu_en    = alu_en_i && !illegal;
  assign op.mul_en    = mul_en_i && !illegal;
  assign op.rf_we     = rf_we_i  && !illegal;
  assign op.illegal   = illegal;

  assign op.operator  = operator_i;
  assign op.operand_a = operand_a_i;
  assign op.operand_b = operand_b_i;
  assign op.rf_waddr  = rf_waddr_i;
  assign op.branch    = branch_i;

  // One-hot unit select seen by both units when an instruction turns valid
  a_unit_onehot : assert property (@(posedge op.valid) !(op.alu_en && op.mul_en))
    else $error("decode: ALU and multiplier enabled together");

endmodule

// File: design/ex_alu.sv
`timescale 1ns/1ns

module ex_alu (
  ex_op_if.unit     op,
  fu_result_if.alu  res,
  output logic      branch_decision_o
);

  import ex_pkg::*;

  word_t      op_a;
  word_t      op_b;
  logic [4:0] shamt;
  logic       eq;
  logic       lt_s;
  logic       lt_u;

  assign op_a  = op.operand_a;
  assign op_b  = op.operand_b;
  // Shift amount from the low five bits of operand b
  assign shamt = op_b[4:0];

  // Shared comparator outputs
  assign eq    = (op_a == op_b);
  assign lt_s  = ($signed(op_a) < $signed(op_b));
  assign lt_u  = (op_a < op_b);

  ////////////////////////////////////////
  // Compare outcome
  ////////////////////////////////////////

  always_comb begin
    unique case (op.operator)
      OP_BEQ:  res.cmp_result = eq;
      OP_BNE:  res.cmp_result = !eq;
      OP_BLT:  res.cmp_result = lt_s;
      OP_BGE:  res.cmp_result = !lt_s;
      OP_BLTU: res.cmp_result = lt_u;
      OP_BGEU: res.cmp_result = !lt_u;
      default: res.cmp_result = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // Data result
  ////////////////////////////////////////

  always_comb begin
    unique case (op.operator)
      OP_ADD:  res.alu_result = op_a + op_b;
      OP_SUB:  res.alu_result = op_a - op_b;
      OP_AND:  res.alu_result = op_a & op_b;
      OP_OR:   res.alu_result = op_a | op_b;
      OP_XOR:  res.alu_result = op_a ^ op_b;
      OP_SLL:  res.alu_result = op_a << shamt;
      OP_SRL:  res.alu_result = op_a >> shamt;
      OP_SRA:  res.alu_result = word_t'($signed(op_a) >>> shamt);
      OP_SLT:  res.alu_result = {31'b0, lt_s};
      OP_SLTU: res.alu_result = {31'b0, lt_u};
      // Compares write their outcome as 0 or 1
      default: res.alu_result = {31'b0, res.cmp_result};
    endcase
  end

  // Decision only for a live, legal ALU branch
  assign branch_decision_o = op.valid && op.alu_en && op.branch && res.cmp_result;

endmodule

// File: design/ex_mult.sv
`timescale 1ns/1ns

module ex_mult (
  input  logic      clk,
  input  logic      rst_n,
  ex_op_if.unit     op,
  fu_result_if.mult res
);

  import ex_pkg::*;

  mult_state_e state;
  mult_cnt_t   cnt;
  logic        start;

  // Multiplicand, accumulator with multiplier in the low half, word select
  word_t       mcand;
  logic [63:0] acc;
  logic        hi_sel;
  logic [32:0] partial;
  logic [63:0] acc_step;

  assign start = op.valid && op.mul_en;

  // One shift-add step, carry kept in bit 32 of the partial sum
  assign partial  = {1'b0, acc[63:32]} + (acc[0] ? {1'b0, mcand} : 33'd0);
  assign acc_step = {partial, acc[31:1]};

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= MULT_IDLE;
      cnt   <= '0;
    end else if (op.kill) begin
      state <= MULT_IDLE;
    end else begin
      unique case (state)
        MULT_IDLE: if (start) begin
          state <= MULT_BUSY;
          cnt   <= '0;
        end
        MULT_BUSY: begin
          cnt <= cnt + 1'b1;
          if (cnt == MULT_LAST) state <= MULT_DONE;
        end
        // Result held until writeback takes it
        MULT_DONE: if (res.wb_ready) state <= MULT_IDLE;
        default:   state <= MULT_IDLE;
      endcase
    end
  end

  // Operand capture and datapath
  always_ff @(posedge clk) begin
    if (state == MULT_IDLE && start) begin
      mcand  <= op.operand_a;
      acc    <= {32'b0, op.operand_b};
      hi_sel <= (op.operator == OP_MULHU);
    end else if (state == MULT_BUSY) begin
      acc <= acc_step;
    end
  end

  assign res.mul_result = hi_sel ? acc[63:32] : acc[31:0];
  assign res.mul_valid  = (state == MULT_DONE);
  // Not ready while a multiply is pending or in flight
  assign res.mul_ready  = (state == MULT_IDLE) ? !start : (state == MULT_DONE);

  // A valid result is only reached through the busy steps, never straight from idle
  a_valid_done : assert property (@(posedge clk) disable iff (!rst_n)
    res.mul_valid |-> state == MULT_DONE && $past(state) != MULT_IDLE)
    else $error("mult: result valid outside MULT_DONE");

  a_kill_idle : assert property (@(posedge clk) disable iff (!rst_n)
    op.kill |=> state == MULT_IDLE)
    else $error("mult: kill did not return to MULT_IDLE");

endmodule

// File: design/ex_wb_register.sv
`timescale 1ns/1ns

module ex_wb_register (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                wb_ready_i,
  ex_op_if.result             op,
  fu_result_if.result         res,
  output logic                ex_ready_o,
  output logic                wb_valid_o,
  output logic                wb_rf_we_o,
  output logic                wb_illegal_o,
  output logic                wb_branch_taken_o,
  output ex_pkg::reg_addr_t   wb_rf_waddr_o,
  output ex_pkg::word_t       wb_rf_wdata_o
);

  import ex_pkg::*;

  logic  ex_valid;
  word_t wdata_sel;
  logic  taken;

  assign res.wb_ready = wb_ready_i;

  ////////////////////////////////////////
  // Stage handshake
  ////////////////////////////////////////

  // ALU work, finished multiply or illegal instruction
  assign ex_valid   = op.valid && (op.alu_en || (op.mul_en && res.mul_valid) || op.illegal);

  // Kill frees the stage at once, halt holds it
  assign ex_ready_o = op.kill || (wb_ready_i && res.mul_ready && !op.halt);

  // Write data mux
  assign wdata_sel  = op.alu_en ? res.alu_result : res.mul_result;
  assign taken      = op.branch && op.alu_en && res.cmp_result;

  ////////////////////////////////////////
  // EX/WB pipeline register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_o        <= 1'b0;
      wb_rf_we_o        <= 1'b0;
      wb_illegal_o      <= 1'b0;
      wb_branch_taken_o <= 1'b0;
    end else if (ex_valid && wb_ready_i) begin
      wb_valid_o        <= 1'b1;
      wb_rf_we_o        <= op.rf_we;
      wb_illegal_o      <= op.illegal;
      wb_branch_taken_o <= taken;
    end else if (wb_ready_i) begin
      // Nothing leaves EX, bubble into WB
      wb_valid_o <= 1'b0;
    end
  end

  // Payload fields
  always_ff @(posedge clk) begin
    if (ex_valid && wb_ready_i) begin
      wb_rf_waddr_o <= op.rf_waddr;
      wb_rf_wdata_o <= wdata_sel;
    end
  end

  a_wb_hold : assert property (@(posedge clk) disable iff (!rst_n)
    !wb_ready_i |=> $stable(wb_valid_o) && $stable(wb_rf_we_o) &&
                    $stable(wb_rf_waddr_o) && $stable(wb_rf_wdata_o) &&
                    $stable(wb_illegal_o) && $stable(wb_branch_taken_o))
    else $error("wb_register: output changed under back-pressure");

endmodule

// File: design/ex_stage_top.sv
`timescale 1ns/1ns

module ex_stage_top (
  input  logic              clk,
  input  logic              rst_n,
  // Issue side
  input  logic              instr_valid_i,
  input  logic              kill_i,
  input  logic              halt_i,
  input  logic              alu_en_i,
  input  logic              mul_en_i,
  input  ex_pkg::op_code_t  operator_i,
  input  ex_pkg::word_t     operand_a_i,
  input  ex_pkg::word_t     operand_b_i,
  input  logic              branch_i,
  input  logic              rf_we_i,
  input  ex_pkg::reg_addr_t rf_waddr_i,
  output logic              ex_ready_o,
  output logic              branch_decision_o,
  // Writeback side
  input  logic              wb_ready_i,
  output logic              wb_valid_o,
  output logic              wb_rf_we_o,
  output ex_pkg::reg_addr_t wb_rf_waddr_o,
  output ex_pkg::word_t     wb_rf_wdata_o,
  output logic              wb_illegal_o,
  output logic              wb_branch_taken_o
);

  import ex_pkg::*;

  ex_op_if     op_bus ();
  fu_result_if fu_bus ();

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  ex_issue_decode u_decode (
    .instr_valid_i (instr_valid_i),
    .kill_i        (kill_i),
    .halt_i        (halt_i),
    .alu_en_i      (alu_en_i),
    .mul_en_i      (mul_en_i),
    .branch_i      (branch_i),
    .rf_we_i       (rf_we_i),
    .operator_i    (operator_i),
    .operand_a_i   (operand_a_i),
    .operand_b_i   (operand_b_i),
    .rf_waddr_i    (rf_waddr_i),
    .op            (op_bus.decode)
  );

  ////////////////////////////////////////
  // Functional units
  ////////////////////////////////////////

  ex_alu u_alu (
    .op                (op_bus.unit),
    .res               (fu_bus.alu),
    .branch_decision_o (branch_decision_o)
  );

  ex_mult u_mult (
    .clk   (clk),
    .rst_n (rst_n),
    .op    (op_bus.unit),
    .res   (fu_bus.mult)
  );

  // Result select and EX/WB register
  ex_wb_register u_wb_reg (
    .clk               (clk),
    .rst_n             (rst_n),
    .wb_ready_i        (wb_ready_i),
    .op                (op_bus.result),
    .res               (fu_bus.result),
    .ex_ready_o        (ex_ready_o),
    .wb_valid_o        (wb_valid_o),
    .wb_rf_we_o        (wb_rf_we_o),
    .wb_illegal_o      (wb_illegal_o),
    .wb_branch_taken_o (wb_branch_taken_o),
    .wb_rf_waddr_o     (wb_rf_waddr_o),
    .wb_rf_wdata_o     (wb_rf_wdata_o)
  );

endmodule

// File: test/ex_stage_tb.sv
`timescale 1ns/1ns

module ex_stage_tb;

  import ex_pkg::*;

  localparam int N_INSTR        = 400;
  // Slowest instruction is a multiply, doubled for back-pressure and halts
  localparam int TIMEOUT_CYCLES = N_INSTR * (MULT_CYCLES + 8) * 2;

  // Expected EX/WB contents of one accepted instruction
  typedef struct packed {
    logic      we;
    reg_addr_t waddr;
    word_t     wdata;
    logic      illegal;
    logic      taken;
  } exp_t;

  logic      clk;
  logic      rst_n;
  logic      instr_valid_i;
  logic      kill_i;
  logic      halt_i;
  logic      alu_en_i;
  logic      mul_en_i;
  op_code_t  operator_i;
  word_t     operand_a_i;
  word_t     operand_b_i;
  logic      branch_i;
  logic      rf_we_i;
  reg_addr_t rf_waddr_i;
  logic      wb_ready_i;
  logic      ex_ready_o;
  logic      branch_decision_o;
  logic      wb_valid_o;
  logic      wb_rf_we_o;
  reg_addr_t wb_rf_waddr_o;
  word_t     wb_rf_wdata_o;
  logic      wb_illegal_o;
  logic      wb_branch_taken_o;

  // Reference queue, oldest accepted instruction at the front
  exp_t      exp_q[$];
  exp_t      cur_exp;
  logic      cur_taken;
  logic      head_valid;
  logic      head_we;
  reg_addr_t head_waddr;
  word_t     head_wdata;
  logic      head_illegal;
  logic      head_taken;
  // Legal multiply not yet seen by the multiplier
  logic      mul_fresh;
  logic [31:0] rng;
  int        issued;
  int        accepted;
  int        retired;
  int        killed;
  int        errors;
  int        cycles;

  ex_stage_top u_ex_stage_top (
    .clk               (clk),
    .rst_n             (rst_n),
    .instr_valid_i     (instr_valid_i),
    .kill_i            (kill_i),
    .halt_i            (halt_i),
    .alu_en_i          (alu_en_i),
    .mul_en_i          (mul_en_i),
    .operator_i        (operator_i),
    .operand_a_i       (operand_a_i),
    .operand_b_i       (operand_b_i),
    .branch_i          (branch_i),
    .rf_we_i           (rf_we_i),
    .rf_waddr_i        (rf_waddr_i),
    .ex_ready_o        (ex_ready_o),
    .branch_decision_o (branch_decision_o),
    .wb_ready_i        (wb_ready_i),
    .wb_valid_o        (wb_valid_o),
    .wb_rf_we_o        (wb_rf_we_o),
    .wb_rf_waddr_o     (wb_rf_waddr_o),
    .wb_rf_wdata_o     (wb_rf_wdata_o),
    .wb_illegal_o      (wb_illegal_o),
    .wb_branch_taken_o (wb_branch_taken_o)
  );

  // 4 ns period
  always #2 clk = ~clk;

  // xorshift32 step on the shared generator state
  function automatic logic [31:0] rand_word();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic report_mismatch(input string name, input word_t exp_val, input word_t got_val);
    errors++;
    $display("Fail %s exp %h got %h", name, exp_val, got_val);
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic exp_t expect_of(input logic alu_en, input logic mul_en,
                                     input op_code_t opc, input logic br, input logic we,
                                     input reg_addr_t waddr, input word_t a, input word_t b);
    exp_t        e;
    logic [63:0] prod;
    logic        alu_op;
    logic        cmp_op;
    logic        cmp;
    // ALU owns codes 0 to 15, compares are the top six of them
    alu_op = (opc <= OP_BGEU);
    cmp_op = opc inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
    prod   = {32'b0, a} * {32'b0, b};
    e.illegal = (alu_en == mul_en) || (alu_en && !alu_op) ||
                (mul_en && !(opc inside {OP_MUL, OP_MULHU})) || (br && !cmp_op);
    case (opc)
      OP_BEQ:  cmp = (a == b);
      OP_BNE:  cmp = (a != b);
      OP_BLT:  cmp = ($signed(a) < $signed(b));
      OP_BGE:  cmp = ($signed(a) >= $signed(b));
      OP_BLTU: cmp = (a < b);
      OP_BGEU: cmp = (a >= b);
      default: cmp = 1'b0;
    endcase
    case (opc)
      OP_ADD:   e.wdata = a + b;
      OP_SUB:   e.wdata = a - b;
      OP_AND:   e.wdata = a & b;
      OP_OR:    e.wdata = a | b;
      OP_XOR:   e.wdata = a ^ b;
      OP_SLL:   e.wdata = a << b[4:0];
      OP_SRL:   e.wdata = a >> b[4:0];
      OP_SRA:   e.wdata = $signed(a) >>> b[4:0];
      OP_SLT:   e.wdata = {31'b0, $signed(a) < $signed(b)};
      OP_SLTU:  e.wdata = {31'b0, a < b};
      OP_MUL:   e.wdata = prod[31:0];
      OP_MULHU: e.wdata = prod[63:32];
      // Compares write the outcome as 0 or 1
      default:  e.wdata = {31'b0, cmp};
    endcase
    e.we    = we && !e.illegal;
    e.waddr = waddr;
    e.taken = !e.illegal && alu_en && br && cmp;
    return e;
  endfunction

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic issue_next();
    logic [31:0] r;
    logic        alu_en;
    logic        mul_en;
    logic        br;
    op_code_t    opc;
    word_t       a;
    word_t       b;
    r = rand_word();
    if (issued >= N_INSTR || r[2:0] == 3'd0) begin
      instr_valid_i <= 1'b0;
      mul_fresh = 1'b0;
    end else begin
      // Mostly ALU, one in eight multiplies, a few bad unit pairs
      case (r[6:3])
        4'd0:       {alu_en, mul_en} = 2'b11;
        4'd1:       {alu_en, mul_en} = 2'b00;
        4'd2, 4'd3: {alu_en, mul_en} = 2'b01;
        default:    {alu_en, mul_en} = 2'b10;
      endcase
      if (r[10:7] == 4'd0)
        opc = r[15:11];
      else if (mul_en)
        opc = r[11] ? OP_MULHU : OP_MUL;
      else
        opc = {1'b0, r[14:11]};
      // Branch flag on compares half the time, rarely on anything else
      br = (opc inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU}) ?
           r[16] : (r[20:17] == 4'd0);
      a = rand_word();
      // Equal operands now and then for BEQ and BGE
      b = (r[23:21] == 3'd0) ? a : rand_word();
      instr_valid_i <= 1'b1;
      alu_en_i      <= alu_en;
      mul_en_i      <= mul_en;
      operator_i    <= opc;
      branch_i      <= br;
      operand_a_i   <= a;
      operand_b_i   <= b;
      rf_we_i       <= r[24];
      rf_waddr_i    <= r[29:25];
      cur_exp   = expect_of(alu_en, mul_en, opc, br, r[24], r[29:25], a, b);
      cur_taken = cur_exp.taken;
      mul_fresh = mul_en && !cur_exp.illegal;
      issued++;
    end
  endtask

  always @(posedge clk) begin
    logic [31:0] r;
    if (rst_n) begin
      if (mul_fresh && instr_valid_i && !kill_i && !halt_i)
        mul_fresh = 1'b0;
      if (instr_valid_i && kill_i)
        killed++;
      // Retire first, then record what leaves EX on this edge
      if (wb_valid_o && wb_ready_i) begin
        retired++;
        if (exp_q.size() > 0)
          void'(exp_q.pop_front());
      end
      if (instr_valid_i && !kill_i && !halt_i && ex_ready_o) begin
        exp_q.push_back(cur_exp);
        accepted++;
      end
      // Issuer holds its inputs until the stage is ready
      if (!instr_valid_i || ex_ready_o)
        issue_next();
      r = rand_word();
      kill_i     <= (r[5:0] == 6'd0);
      halt_i     <= (r[9:7] == 3'd0);
      wb_ready_i <= (r[12:11] != 2'd0);
      head_valid = (exp_q.size() > 0);
      if (head_valid) begin
        head_we      = exp_q[0].we;
        head_waddr   = exp_q[0].waddr;
        head_wdata   = exp_q[0].wdata;
        head_illegal = exp_q[0].illegal;
        head_taken   = exp_q[0].taken;
      end
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  a_no_extra : assert property (@(posedge clk) disable iff (!rst_n)
    (wb_valid_o && wb_ready_i) |-> head_valid)
    else report_error("Writeback delivered an item with no accepted instruction outstanding");

  a_we : assert property (@(posedge clk) disable iff (!rst_n)
    (wb_valid_o && wb_ready_i && head_valid) |-> wb_rf_we_o == head_we)
    else report_mismatch("wb_rf_we_o", $sampled(head_we), $sampled(wb_rf_we_o));

  a_waddr : assert property (@(posedge clk) disable iff (!rst_n)
    (wb_valid_o && wb_ready_i && head_valid) |-> wb_rf_waddr_o == head_waddr)
    else report_mismatch("wb_rf_waddr_o", $sampled(head_waddr), $sampled(wb_rf_waddr_o));

  // Data is don't-care for an illegal instruction
  a_wdata : assert property (@(posedge clk) disable iff (!rst_n)
    (wb_valid_o && wb_ready_i && head_valid && !head_illegal) |-> wb_rf_wdata_o == head_wdata)
    else report_mismatch("wb_rf_wdata_o", $sampled(head_wdata), $sampled(wb_rf_wdata_o));

  a_illegal : assert property (@(posedge clk) disable iff (!rst_n)
    (wb_valid_o && wb_ready_i && head_valid) |-> wb_illegal_o == head_illegal)
    else report_mismatch("wb_illegal_o", $sampled(head_illegal), $sampled(wb_illegal_o));

  a_taken : assert property (@(posedge clk) disable iff (!rst_n)
    (wb_valid_o && wb_ready_i && head_valid) |-> wb_branch_taken_o == head_taken)
    else report_mismatch("wb_branch_taken_o", $sampled(head_taken), $sampled(wb_branch_taken_o));

  a_decision : assert property (@(posedge clk) disable iff (!rst_n)
    (instr_valid_i && !kill_i && !halt_i) |-> branch_decision_o == cur_taken)
    else report_mismatch("branch_decision_o", $sampled(cur_taken), $sampled(branch_decision_o));

  // Held item under back-pressure, X-safe compare
  a_hold : assert property (@(posedge clk) disable iff (!rst_n)
    (wb_valid_o && !wb_ready_i) |=> wb_valid_o &&
      (wb_rf_we_o === $past(wb_rf_we_o)) && (wb_rf_waddr_o === $past(wb_rf_waddr_o)) &&
      (wb_rf_wdata_o === $past(wb_rf_wdata_o)) && (wb_illegal_o === $past(wb_illegal_o)) &&
      (wb_branch_taken_o === $past(wb_branch_taken_o)))
    else report_error("Writeback outputs changed while wb_ready_i was low");

  a_reset_idle : assert property (@(posedge clk) disable iff (!rst_n)
    (accepted == 0) |-> !wb_valid_o)
    else report_error("wb_valid_o went high before any instruction was accepted");

  a_kill_ready : assert property (@(posedge clk) disable iff (!rst_n)
    kill_i |-> ex_ready_o)
    else report_error("Stage was not ready during a kill");

  a_halt_hold : assert property (@(posedge clk) disable iff (!rst_n)
    (halt_i && !kill_i) |-> !ex_ready_o)
    else report_error("Stage was ready during a halt");

  a_bp_ready : assert property (@(posedge clk) disable iff (!rst_n)
    (!wb_ready_i && !kill_i) |-> !ex_ready_o)
    else report_error("Stage was ready while writeback withheld wb_ready_i");

  // A multiply cannot finish on the edge that starts it
  a_mul_wait : assert property (@(posedge clk) disable iff (!rst_n)
    (mul_fresh && instr_valid_i && !kill_i && !halt_i) |-> !ex_ready_o)
    else report_error("Stage was ready on the first cycle of a multiply");

  ////////////////////////////////////////
  // Run control
  ////////////////////////////////////////

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the run hung with %0d of %0d issued and %0d errors",
               cycles, issued, N_INSTR, errors);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    instr_valid_i = 1'b0;
    kill_i        = 1'b0;
    halt_i        = 1'b0;
    alu_en_i      = 1'b0;
    mul_en_i      = 1'b0;
    operator_i    = OP_ADD;
    operand_a_i   = '0;
    operand_b_i   = '0;
    branch_i      = 1'b0;
    rf_we_i       = 1'b0;
    rf_waddr_i    = '0;
    wb_ready_i    = 1'b0;
    cur_exp       = '0;
    cur_taken     = 1'b0;
    head_valid    = 1'b0;
    head_we       = 1'b0;
    head_waddr    = '0;
    head_wdata    = '0;
    head_illegal  = 1'b0;
    head_taken    = 1'b0;
    mul_fresh     = 1'b0;
    rng           = 32'd66;
    issued        = 0;
    accepted      = 0;
    retired       = 0;
    killed        = 0;
    errors        = 0;
    cycles        = 0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    // Drain until every issued instruction is resolved and retired
    @(negedge clk);
    while (issued < N_INSTR || instr_valid_i || exp_q.size() > 0)
      @(negedge clk);
    repeat (4) @(negedge clk);
    if (exp_q.size() != 0 || retired != accepted)
      report_error("Retired item count does not match accepted instruction count");
    $display("Issued %0d, accepted %0d, killed %0d, retired %0d, errors %0d",
             issued, accepted, killed, retired, errors);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: ex_stage.f
design/ex_pkg.sv
design/ex_op_if.sv
design/fu_result_if.sv
design/ex_issue_decode.sv
design/ex_alu.sv
design/ex_mult.sv
design/ex_wb_register.sv
design/ex_stage_top.sv
test/ex_stage_tb.sv
